// File: rtl/i2c_pkg.sv
package i2c_pkg;

	// clk cycles per quarter of an SCL bit, 4 quarters give ~200 kHz at 50 MHz
	localparam int SCL_QUARTER_CYCLES = 62;

	typedef logic [7:0]  byte_t;       // one byte on the wire
	typedef logic [6:0]  dev_addr_t;   // 7-bit slave address
	typedef logic [15:0] reg_addr_t;   // 1-byte devices use the low half

	typedef enum logic
	{
		XFER_WRITE,
		XFER_READ
	} op_t;

	// engine phases, each one or more bit periods long
	typedef enum logic [2:0]
	{
		IDLE,
		START,
		SEND_BYTE,
		GET_ACK,
		RESTART,
		RECV_BYTE,
		SEND_ACK,
		STOP
	} engine_state_t;

endpackage

// File: rtl/sensor_pkg.sv
package sensor_pkg;

	// 7-bit forms of the 0x90 and 0xEC write addresses
	localparam logic [6:0] TEMP_DEV = 7'h48;   // temperature, 2-byte reg addr
	localparam logic [6:0] ALT_DEV  = 7'h76;   // altitude, 1-byte reg addr

	localparam int STEP_COUNT   = 37;   // steps in one pass
	localparam int RESULT_BYTES = 32;   // byte slots in the result

	typedef logic [5:0] step_idx_t;
	typedef logic [4:0] slot_t;
	typedef logic [RESULT_BYTES*8-1:0] result_t;   // slot 0 is the top byte
	typedef logic [1:0] rd_len_t;                  // 1 or 2 bytes per read

	// one line of the command table
	typedef struct packed
	{
		i2c_pkg::op_t       op;
		i2c_pkg::dev_addr_t dev;
		i2c_pkg::reg_addr_t reg_addr;
		i2c_pkg::byte_t     wr_data;
		rd_len_t            rd_len;
		slot_t              slot;      // first result slot, reads only
	} step_t;

endpackage

// File: rtl/i2c_xfer_engine.sv
`timescale 1ns/1ps

module i2c_xfer_engine
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cmd,
	input  i2c_pkg::op_t          op,
	input  i2c_pkg::dev_addr_t    dev_addr,
	input  i2c_pkg::reg_addr_t    reg_addr,
	input  logic                  reg_addr_len,
	input  i2c_pkg::byte_t        wr_data,
	input  sensor_pkg::rd_len_t   rd_len,
	input  logic                  sda_in,
	output logic                  scl,
	output logic                  sda_low,
	output logic                  rd_valid,
	output i2c_pkg::byte_t        rd_byte,
	output logic                  rd_index,
	output logic                  xfer_done,
	output logic                  xfer_nack
);

	i2c_pkg::engine_state_t state;

	logic [$clog2(i2c_pkg::SCL_QUARTER_CYCLES)-1:0] qcnt;
	logic                 tick;        // end of a quarter bit
	logic [1:0]           ph;          // quarter within the bit
	logic [2:0]           bit_cnt;
	logic [1:0]           byte_cnt;    // sent bytes, later the read index
	logic                 rd_phase;    // past the repeated start
	i2c_pkg::byte_t       shift;

	i2c_pkg::op_t         op_r;
	i2c_pkg::dev_addr_t   dev_r;
	i2c_pkg::reg_addr_t   reg_r;
	logic                 len_r;
	i2c_pkg::byte_t       wr_r;
	sensor_pkg::rd_len_t  rd_len_r;

	logic [1:0]           addr_bytes;
	logic                 last_byte;

	assign tick       = (qcnt == ($bits(qcnt))'(i2c_pkg::SCL_QUARTER_CYCLES - 1));
	assign addr_bytes = len_r ? 2'd2 : 2'd1;
	assign last_byte  = ((byte_cnt + 2'd1) == rd_len_r);   // master NACKs this one
	assign rd_byte    = shift;
	assign rd_index   = byte_cnt[0];

	// command fields held for the whole transaction
	always_ff @(posedge clk)
	begin
		if (state == i2c_pkg::IDLE && cmd)
		begin
			op_r     <= op;
			dev_r    <= dev_addr;
			reg_r    <= reg_addr;
			len_r    <= reg_addr_len;
			wr_r     <= wr_data;
			rd_len_r <= rd_len;
		end
	end

	// ph 0->1 mid low (sda moves), 1->2 scl rises, 2->3 mid high (sample), 3->0 scl falls
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= i2c_pkg::IDLE;
			qcnt      <= '0;
			ph        <= '0;
			scl       <= 1'b1;
			sda_low   <= 1'b0;
			bit_cnt   <= '0;
			byte_cnt  <= '0;
			rd_phase  <= 1'b0;
			shift     <= '0;
			rd_valid  <= 1'b0;
			xfer_done <= 1'b0;
			xfer_nack <= 1'b0;
		end
		else
		begin
			rd_valid  <= 1'b0;
			xfer_done <= 1'b0;
			if (state == i2c_pkg::IDLE)
			begin
				qcnt <= '0;
				ph   <= '0;
				if (cmd)
				begin
					state     <= i2c_pkg::START;
					shift     <= {dev_addr, 1'b0};   // write direction first
					bit_cnt   <= '0;
					byte_cnt  <= '0;
					rd_phase  <= 1'b0;
					xfer_nack <= 1'b0;
				end
			end
			else if (!tick)
				qcnt <= qcnt + 1'b1;
			else
			begin
				qcnt <= '0;
				ph   <= ph + 2'd1;
				if (ph == 2'd1)
					scl <= 1'b1;
				if (ph == 2'd3)
					scl <= (state == i2c_pkg::STOP);   // bus left idle high
				case (state)
					i2c_pkg::START:
					begin
						if (ph == 2'd1)
							sda_low <= 1'b1;   // falls while scl high
						if (ph == 2'd3)
							state <= i2c_pkg::SEND_BYTE;
					end
					i2c_pkg::SEND_BYTE:
					begin
						if (ph == 2'd0)
							sda_low <= ~shift[7];   // msb first
						if (ph == 2'd3)
						begin
							shift   <= {shift[6:0], 1'b0};
							bit_cnt <= bit_cnt + 3'd1;
							if (bit_cnt == 3'd7)
								state <= i2c_pkg::GET_ACK;
						end
					end
					i2c_pkg::GET_ACK:
					begin
						if (ph == 2'd0)
							sda_low <= 1'b0;   // let the slave drive
						if (ph == 2'd2 && sda_in)
							xfer_nack <= 1'b1;
						if (ph == 2'd3)
						begin
							if (xfer_nack)
								state <= i2c_pkg::STOP;
							else if (rd_phase)
							begin
								byte_cnt <= '0;
								state    <= i2c_pkg::RECV_BYTE;
							end
							else if (byte_cnt < addr_bytes)
							begin
								shift    <= (byte_cnt == 2'd0 && len_r) ? reg_r[15:8] : reg_r[7:0];
								byte_cnt <= byte_cnt + 2'd1;
								state    <= i2c_pkg::SEND_BYTE;
							end
							else if (byte_cnt == addr_bytes && op_r == i2c_pkg::XFER_WRITE)
							begin
								shift    <= wr_r;
								byte_cnt <= byte_cnt + 2'd1;
								state    <= i2c_pkg::SEND_BYTE;
							end
							else if (byte_cnt == addr_bytes)
								state <= i2c_pkg::RESTART;
							else
								state <= i2c_pkg::STOP;   // data byte acked
						end
					end
					i2c_pkg::RESTART:
					begin
						if (ph == 2'd0)
							sda_low <= 1'b0;
						if (ph == 2'd2)
							sda_low <= 1'b1;   // repeated start
						if (ph == 2'd3)
						begin
							shift    <= {dev_r, 1'b1};
							rd_phase <= 1'b1;
							state    <= i2c_pkg::SEND_BYTE;
						end
					end
					i2c_pkg::RECV_BYTE:
					begin
						if (ph == 2'd0)
							sda_low <= 1'b0;
						if (ph == 2'd2)
							shift <= {shift[6:0], sda_in};
						if (ph == 2'd3)
						begin
							bit_cnt <= bit_cnt + 3'd1;
							if (bit_cnt == 3'd7)
							begin
								rd_valid <= 1'b1;
								state    <= i2c_pkg::SEND_ACK;
							end
						end
					end
					i2c_pkg::SEND_ACK:
					begin
						if (ph == 2'd0)
							sda_low <= ~last_byte;
						if (ph == 2'd3)
						begin
							if (last_byte)
								state <= i2c_pkg::STOP;
							else
							begin
								byte_cnt <= byte_cnt + 2'd1;
								state    <= i2c_pkg::RECV_BYTE;
							end
						end
					end
					i2c_pkg::STOP:
					begin
						if (ph == 2'd0)
							sda_low <= 1'b1;
						if (ph == 2'd2)
							sda_low <= 1'b0;   // rises while scl high
						if (ph == 2'd3)
						begin
							xfer_done <= 1'b1;
							state     <= i2c_pkg::IDLE;
						end
					end
					default:
						state <= i2c_pkg::IDLE;
				endcase
			end
		end
	end

endmodule

// File: rtl/sensor_script.sv
`timescale 1ns/1ps

module sensor_script
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic                 xfer_done,
	input  logic                 xfer_nack,
	output logic                 busy,
	output logic                 done,
	output logic                 clear,
	output logic                 cmd,
	output i2c_pkg::op_t         op,
	output i2c_pkg::dev_addr_t   dev_addr,
	output i2c_pkg::reg_addr_t   reg_addr,
	output logic                 reg_addr_len,
	output i2c_pkg::byte_t       wr_data,
	output sensor_pkg::rd_len_t  rd_len,
	output sensor_pkg::slot_t    slot_base
);

	sensor_pkg::step_idx_t step;
	sensor_pkg::step_t     rec;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			step  <= '0;
			busy  <= 1'b0;
			done  <= 1'b0;
			clear <= 1'b0;
			cmd   <= 1'b0;
		end
		else
		begin
			done  <= 1'b0;
			clear <= 1'b0;
			cmd   <= 1'b0;
			if (!busy && start)
			begin
				step  <= '0;
				busy  <= 1'b1;
				clear <= 1'b1;
				cmd   <= 1'b1;
			end
			else if (busy && xfer_done)
			begin
				if (xfer_nack)
					cmd <= 1'b1;   // same step again
				else if (step == sensor_pkg::step_idx_t'(sensor_pkg::STEP_COUNT - 1))
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				else
				begin
					step <= step + 6'd1;
					cmd  <= 1'b1;
				end
			end
		end
	end

	// command table
	always_comb
	begin
		rec          = '0;
		rec.op       = i2c_pkg::XFER_READ;
		rec.dev      = sensor_pkg::ALT_DEV;
		rec.rd_len   = 2'd1;
		rec.slot     = sensor_pkg::slot_t'(step - 6'd5);   // altitude reads land in 2..31
		case (step)
			6'd0, 6'd1, 6'd2:
			begin
				rec.op       = i2c_pkg::XFER_WRITE;
				rec.dev      = sensor_pkg::TEMP_DEV;
				rec.reg_addr = {14'd0, step[1:0]} + 16'd1;   // config, thyst, tos
			end
			6'd3:
			begin
				rec.dev      = sensor_pkg::TEMP_DEV;
				rec.reg_addr = 16'h0000;   // temperature, 2 bytes
				rec.rd_len   = 2'd2;
				rec.slot     = '0;
			end
			6'd4:
			begin
				rec.op       = i2c_pkg::XFER_WRITE;
				rec.reg_addr = 16'h00E0;   // soft reset
				rec.wr_data  = 8'hB6;
			end
			6'd5:
			begin
				rec.op       = i2c_pkg::XFER_WRITE;
				rec.reg_addr = 16'h00F4;   // ctrl_meas
				rec.wr_data  = 8'hFF;
			end
			6'd6:
			begin
				rec.op       = i2c_pkg::XFER_WRITE;
				rec.reg_addr = 16'h00F5;   // config
			end
			default:
			begin
				if (step < 6'd31)
					rec.reg_addr = {8'h00, (8'h81 + {2'b00, step}) ^ 8'h01};   // 0x89, 0x88, 0x8B...
				else if (step < 6'd34)
					rec.reg_addr = {8'h00, 8'hDB + {2'b00, step}};   // temp raw FA..FC
				else
					rec.reg_addr = {8'h00, 8'hD5 + {2'b00, step}};   // press raw F7..F9
			end
		endcase
	end

	assign op           = rec.op;
	assign dev_addr     = rec.dev;
	assign reg_addr     = rec.reg_addr;
	assign reg_addr_len = (rec.dev == sensor_pkg::TEMP_DEV);
	assign wr_data      = rec.wr_data;
	assign rd_len       = rec.rd_len;
	assign slot_base    = rec.slot;

endmodule

// File: rtl/result_packer.sv
`timescale 1ns/1ps

module result_packer
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 clear,
	input  logic                 rd_valid,
	input  i2c_pkg::byte_t       rd_byte,
	input  logic                 rd_index,
	input  sensor_pkg::slot_t    slot_base,
	output sensor_pkg::result_t  dout
);

	sensor_pkg::slot_t slot;
	logic [7:0]        lsb;

	// step position from the script plus byte position from the engine
	assign slot = slot_base + {4'd0, rd_index};

	// slot 0 is the top byte, so its lsb sits at 8*(31 - slot)
	assign lsb = {~slot, 3'b000};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			dout <= '0;
		else if (clear)
			dout <= '0;   // new pass
		else if (rd_valid)
			dout[lsb +: 8] <= rd_byte;
	end

endmodule

// File: rtl/sensor_hub.sv
`timescale 1ns/1ps

module sensor_hub
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  logic                 sda_in,
	output logic                 scl,
	output logic                 sda_low,
	output logic                 busy,
	output logic                 done,
	output sensor_pkg::result_t  dout
);

	logic                 clear;
	logic                 cmd;
	i2c_pkg::op_t         op;
	i2c_pkg::dev_addr_t   dev_addr;
	i2c_pkg::reg_addr_t   reg_addr;
	logic                 reg_addr_len;
	i2c_pkg::byte_t       wr_data;
	sensor_pkg::rd_len_t  rd_len;
	sensor_pkg::slot_t    slot_base;
	logic                 rd_valid;
	i2c_pkg::byte_t       rd_byte;
	logic                 rd_index;
	logic                 xfer_done;
	logic                 xfer_nack;

	sensor_script i_sensor_script
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.start        (start),
		.xfer_done    (xfer_done),
		.xfer_nack    (xfer_nack),
		.busy         (busy),
		.done         (done),
		.clear        (clear),
		.cmd          (cmd),
		.op           (op),
		.dev_addr     (dev_addr),
		.reg_addr     (reg_addr),
		.reg_addr_len (reg_addr_len),
		.wr_data      (wr_data),
		.rd_len       (rd_len),
		.slot_base    (slot_base)
	);

	i2c_xfer_engine i_i2c_xfer_engine
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd          (cmd),
		.op           (op),
		.dev_addr     (dev_addr),
		.reg_addr     (reg_addr),
		.reg_addr_len (reg_addr_len),
		.wr_data      (wr_data),
		.rd_len       (rd_len),
		.sda_in       (sda_in),
		.scl          (scl),
		.sda_low      (sda_low),
		.rd_valid     (rd_valid),
		.rd_byte      (rd_byte),
		.rd_index     (rd_index),
		.xfer_done    (xfer_done),
		.xfer_nack    (xfer_nack)
	);

	result_packer i_result_packer
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.clear     (clear),
		.rd_valid  (rd_valid),
		.rd_byte   (rd_byte),
		.rd_index  (rd_index),
		.slot_base (slot_base),
		.dout      (dout)
	);

endmodule

// File: verification/i2c_sensor_model.sv
`timescale 1ns/1ps

module i2c_sensor_model
#(
	parameter int NACK_XACT = 5   // transaction whose address byte goes unacked
)
(
	input  logic clk,
	input  logic rst_n,
	input  logic scl,
	input  logic sda,
	output logic slave_low
);

	typedef enum logic [2:0]
	{
		M_IDLE,
		M_RX,
		M_ACK,
		M_TX,
		M_MACK
	} mode_t;

	logic [7:0] temp_rom [0:1];     // temperature word set by the testbench
	logic [7:0] alt_rom  [0:255];   // altitude read registers set by the testbench
	logic [7:0] temp_wr_val [0:255];
	logic [7:0] alt_wr_val  [0:255];
	int         temp_wr_cnt [0:255];
	int         alt_wr_cnt  [0:255];

	mode_t      mode;
	logic       prev_scl;
	logic       prev_sda;
	logic [3:0] bitc;
	logic [7:0] shift;
	logic [2:0] byte_idx;
	logic       is_temp;
	logic       rw;
	logic [7:0] ptr;
	logic       rd_cnt;
	int         xact_cnt;       // write device bytes seen
	logic       injected;
	logic [7:0] first_tx;       // byte sent after the address ack
	logic [7:0] next_tx;        // byte sent after a master ack

	function automatic logic [7:0] tx_byte(input logic temp, input logic idx,
		input logic [7:0] addr);
		if (temp)
			return temp_rom[idx];
		return alt_rom[addr];
	endfunction

	assign first_tx = tx_byte(is_temp, rd_cnt, ptr);
	assign next_tx  = tx_byte(is_temp, 1'b1, ptr + 8'd1);

	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mode      <= M_IDLE;
			prev_scl  <= 1'b1;
			prev_sda  <= 1'b1;
			slave_low <= 1'b0;
			bitc      <= '0;
			shift     <= '0;
			byte_idx  <= '0;
			is_temp   <= 1'b0;
			rw        <= 1'b0;
			ptr       <= '0;
			rd_cnt    <= 1'b0;
			xact_cnt  <= 0;
			injected  <= 1'b0;
			for (int i = 0; i < 256; i++)
			begin
				temp_wr_val[i] <= '0;
				alt_wr_val[i]  <= '0;
				temp_wr_cnt[i] <= 0;
				alt_wr_cnt[i]  <= 0;
			end
		end
		else
		begin
			prev_scl <= scl;
			prev_sda <= sda;
			if (scl && prev_scl && prev_sda && !sda)
			begin
				mode      <= M_RX;   // start or repeated start
				bitc      <= '0;
				byte_idx  <= '0;
				slave_low <= 1'b0;
			end
			else if (scl && prev_scl && !prev_sda && sda)
				mode <= M_IDLE;   // stop
			else if (scl && !prev_scl)
			begin
				if (mode == M_RX)
				begin
					shift <= {shift[6:0], sda};
					bitc  <= bitc + 4'd1;
				end
				else if (mode == M_TX)
					bitc <= bitc + 4'd1;
				else if (mode == M_MACK)
					rw <= ~sda;   // master ack keeps the read going
			end
			else if (!scl && prev_scl)
			begin
				case (mode)
					M_RX:
					begin
						if (bitc == 4'd8)
						begin
							bitc     <= '0;
							byte_idx <= byte_idx + 3'd1;
							if (byte_idx == 3'd0)
							begin
								if (shift[7:1] != 7'h48 && shift[7:1] != 7'h76)
									mode <= M_IDLE;
								else if (!shift[0] && xact_cnt == NACK_XACT - 1 && !injected)
								begin
									injected <= 1'b1;   // one-time NACK
									xact_cnt <= xact_cnt + 1;
									mode     <= M_IDLE;
								end
								else
								begin
									if (!shift[0])
										xact_cnt <= xact_cnt + 1;
									is_temp   <= (shift[7:1] == 7'h48);
									rw        <= shift[0];
									rd_cnt    <= 1'b0;
									slave_low <= 1'b1;
									mode      <= M_ACK;
								end
							end
							else
							begin
								if (byte_idx == (is_temp ? 3'd2 : 3'd1))
									ptr <= shift;
								else if (byte_idx > (is_temp ? 3'd2 : 3'd1))
								begin
									if (is_temp)
									begin
										temp_wr_val[ptr] <= shift;
										temp_wr_cnt[ptr] <= temp_wr_cnt[ptr] + 1;
									end
									else
									begin
										alt_wr_val[ptr] <= shift;
										alt_wr_cnt[ptr] <= alt_wr_cnt[ptr] + 1;
									end
									ptr <= ptr + 8'd1;
								end
								slave_low <= 1'b1;
								mode      <= M_ACK;
							end
						end
					end
					M_ACK:
					begin
						if (rw)
						begin
							slave_low <= ~first_tx[7];
							shift     <= {first_tx[6:0], 1'b0};
							bitc      <= '0;
							mode      <= M_TX;
						end
						else
						begin
							slave_low <= 1'b0;
							mode      <= M_RX;
						end
					end
					M_TX:
					begin
						if (bitc == 4'd8)
						begin
							slave_low <= 1'b0;   // master acks now
							mode      <= M_MACK;
						end
						else
						begin
							slave_low <= ~shift[7];
							shift     <= {shift[6:0], 1'b0};
						end
					end
					M_MACK:
					begin
						if (rw)
						begin
							slave_low <= ~next_tx[7];
							shift     <= {next_tx[6:0], 1'b0};
							ptr       <= ptr + 8'd1;
							rd_cnt    <= 1'b1;
							bitc      <= '0;
							mode      <= M_TX;
						end
						else
							mode <= M_IDLE;   // master NACKed the last byte
					end
					default:
						slave_low <= 1'b0;
				endcase
			end
		end
	end

endmodule

// File: verification/tb_sensor_hub.sv
`timescale 1ns/1ps

module tb_sensor_hub;

	localparam logic [31:0] LCG_SEED = 32'hc12c_692f;
	localparam int NACK_XACT = 5;   // fifth transaction loses its address ack
	localparam int WATCHDOG_NS = 2 * 38 * 50 * 4 * i2c_pkg::SCL_QUARTER_CYCLES * 20 * 2;

	logic clk;
	logic rst_n;
	logic start;
	logic scl;
	logic sda_low;
	logic slave_low;
	logic sda;
	logic busy;
	logic done;
	sensor_pkg::result_t dout;
	sensor_pkg::result_t expected;

	logic [7:0] temp_bytes [0:1];
	logic [7:0] alt_bytes  [0:255];
	logic [31:0] seed;
	logic mon_scl;
	logic mon_sda;
	int   done_count;

	assign sda = ~(sda_low | slave_low);   // open-drain wired AND

	sensor_hub i_sensor_hub
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.sda_in  (sda),
		.scl     (scl),
		.sda_low (sda_low),
		.busy    (busy),
		.done    (done),
		.dout    (dout)
	);

	i2c_sensor_model
	#(
		.NACK_XACT (NACK_XACT)
	)
	i_model
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.scl       (scl),
		.sda       (sda),
		.slave_low (slave_low)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// slot order follows the script with temp word, calibration hi/lo pairs, FA..FC, F7..F9
	function automatic sensor_pkg::result_t build_expected();
		sensor_pkg::result_t r;
		int a;
		r = '0;
		r[255 -: 8] = temp_bytes[0];
		r[247 -: 8] = temp_bytes[1];
		for (int j = 0; j < 30; j++)
		begin
			if (j < 24)
				a = 8'h88 + 2 * (j / 2) + ((j % 2 == 0) ? 1 : 0);
			else if (j < 27)
				a = 8'hFA + (j - 24);
			else
				a = 8'hF7 + (j - 27);
			r[239 - 8 * j -: 8] = alt_bytes[a];
		end
		return r;
	endfunction

	task automatic fail_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		fail_run();
	endtask

	task automatic pulse_start();
		@(posedge clk);
		#2 start = 1'b1;
		@(posedge clk);
		#2 start = 1'b0;
	endtask

	task automatic wait_done();
		do
			@(negedge clk);
		while (!done);
	endtask

	task automatic check_writes(input int runs);
		for (int r = 1; r <= 3; r++)
			assert (i_model.temp_wr_cnt[r] == runs && i_model.temp_wr_val[r] == 8'h00)
			else report_mismatch("temperature config register write log wrong");
		assert (i_model.alt_wr_cnt[8'hE0] == runs && i_model.alt_wr_val[8'hE0] == 8'hB6)
		else report_mismatch("altitude reg E0 write log wrong");
		assert (i_model.alt_wr_cnt[8'hF4] == runs && i_model.alt_wr_val[8'hF4] == 8'hFF)
		else report_mismatch("altitude reg F4 write log wrong");
		assert (i_model.alt_wr_cnt[8'hF5] == runs && i_model.alt_wr_val[8'hF5] == 8'h00)
		else report_mismatch("altitude reg F5 write log wrong");
		assert (i_model.injected) else report_mismatch("NACK was never injected");
	endtask

	// reset values
	always @(negedge clk)
		if (!rst_n)
			assert (scl && !sda_low && !busy && !done && dout == '0)
			else report_mismatch("outputs not idle during reset");

	// sda may only move under a high scl as start or stop of an active pass
	always @(negedge clk)
	begin
		if (rst_n && scl && mon_scl && sda != mon_sda)
			assert (busy) else report_mismatch("sda changed while scl high and idle");
		mon_scl <= scl;
		mon_sda <= sda;
	end

	always @(negedge clk)
	begin
		if (rst_n && done)
		begin
			done_count <= done_count + 1;
			assert (dout == expected) else report_mismatch("dout differs on done");
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		fail_run();
	end

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		start = 1'b0;
		mon_scl = 1'b1;
		mon_sda = 1'b1;
		done_count = 0;
		seed = LCG_SEED;
		for (int i = 0; i < 2; i++)
		begin
			seed = lcg_next(seed);
			temp_bytes[i] = seed[31:24];
			i_model.temp_rom[i] = seed[31:24];
		end
		for (int a = 0; a < 256; a++)
		begin
			seed = lcg_next(seed);
			alt_bytes[a] = seed[31:24];
			i_model.alt_rom[a] = seed[31:24];
		end
		expected = build_expected();
		repeat (16) @(posedge clk);
		#2 rst_n = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		assert (scl && !sda_low && !busy && !done && dout == '0)
		else report_mismatch("outputs not idle after reset");
		pulse_start();
		wait (dout != '0);
		pulse_start();   // ignored while the pass runs
		@(posedge clk);
		@(negedge clk);
		assert (busy && dout != '0) else report_mismatch("start while busy restarted the pass");
		wait_done();
		@(negedge clk);
		assert (!done && !busy && done_count == 1)
		else report_mismatch("done not a single strobe ending the pass");
		check_writes(1);
		assert (i_model.xact_cnt == sensor_pkg::STEP_COUNT + 1)   // 37 steps plus the retried one
		else report_mismatch("transaction count wrong after first pass");
		pulse_start();
		@(posedge clk);
		@(negedge clk);
		assert (busy && dout == '0) else report_mismatch("second start did not clear dout");
		wait_done();
		@(negedge clk);
		assert (!busy && done_count == 2) else report_mismatch("second pass did not end once");
		check_writes(2);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: flist.f
rtl/i2c_pkg.sv
rtl/sensor_pkg.sv
rtl/i2c_xfer_engine.sv
rtl/sensor_script.sv
rtl/result_packer.sv
rtl/sensor_hub.sv
verification/i2c_sensor_model.sv
verification/tb_sensor_hub.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
( verilator --binary --timing --assert -f flist.f --top-module tb_sensor_hub -o sim_tb \
	&& ./obj_dir/sim_tb ) > sim.log 2>&1
grep -qF '*** TEST PASSED ***' sim.log && echo "simulation passed" || {
	cat sim.log
	echo "simulation failed"
	exit 1
}
